//--- knightsTour_config.svh
`ifndef KNIGHTSTOUR_CONFIG_SVH
`define KNIGHTSTOUR_CONFIG_SVH

////////////////////////////////////////
// Timing divisors
////////////////////////////////////////

// Clocks per UART bit
`define KT_BAUD_DIV 16

// Clocks per SCLK half period
`define KT_SPI_DIV 4

////////////////////////////////////////
// Response bytes and calibration table
////////////////////////////////////////

// Positive and negative acknowledge
`define KT_ACK 8'hA5
`define KT_NAK 8'h5A

// Number of register writes sent to the inertial sensor
`define KT_CAL_LEN 4

// Register writes in the order they go out
`define KT_CAL_WORD0 16'h0D02
`define KT_CAL_WORD1 16'h1053
`define KT_CAL_WORD2 16'h1150
`define KT_CAL_WORD3 16'h1460

`endif

//--- knightsTourPkg.sv
`default_nettype none

package knightsTourPkg;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  // One UART data byte
  typedef logic [7:0] byteT;

  // Raw command as it comes off the link
  typedef logic [15:0] cmdWordT;

  // Upper nibble of a command
  typedef logic [3:0] opcodeT;

  // Lower twelve bits of a command
  typedef logic [11:0] headingT;

  // One SPI frame to the inertial sensor
  typedef logic [15:0] spiWordT;

  // Command split into its two fields, opcode on top
  typedef struct packed {
    opcodeT  opcode;
    headingT operand;
  } cmdT;

  // Opcodes handled by this front end
  localparam opcodeT OP_CAL  = 4'd2;
  localparam opcodeT OP_MOVE = 4'd4;

  // Command processor states
  typedef enum logic [1:0] {
    IDLE,
    CAL_SEND,
    CAL_WAIT,
    RESPOND
  } procStateT;

endpackage

`default_nettype wire

//--- uartRx.sv
`timescale 1ns/1ps
`default_nettype none
`include "knightsTour_config.svh"

module uartRx (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rx,
  output knightsTourPkg::byteT rxByte,
  output logic                 rxValid
);

  import knightsTourPkg::*;

  localparam int CNT_W = $clog2(`KT_BAUD_DIV);
  // Reload for a full bit, and half a bit to reach the start bit centre
  localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(`KT_BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(`KT_BAUD_DIV / 2 - 1);
  // Slot 0 is the start bit, slots 1 to 8 the data
  localparam logic [3:0] STOP_SLOT = 4'd9;

  logic [2:0]       rxSync;
  logic             rxIn;
  logic             startEdge;
  logic             busy;
  logic [CNT_W-1:0] baudCnt;
  logic [3:0]       bitSlot;
  byteT             shiftReg;

  // Two synchronizer flops plus one history flop, line idles high
  always_ff @(posedge clk) begin
    if (reset) begin
      rxSync <= 3'b111;
    end else begin
      rxSync <= {rxSync[1:0], rx};
    end
  end

  assign rxIn      = rxSync[1];
  assign startEdge = rxSync[2] && !rxSync[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      baudCnt <= '0;
      bitSlot <= '0;
      rxValid <= 1'b0;
    end else begin
      rxValid <= 1'b0;
      if (!busy) begin
        // Wait for the falling edge of a start bit
        if (startEdge) begin
          busy    <= 1'b1;
          baudCnt <= HALF_LOAD;
          bitSlot <= '0;
        end
      end else if (baudCnt != '0) begin
        baudCnt <= baudCnt - 1'b1;
      end else begin
        // Centre of the current bit slot
        baudCnt <= FULL_LOAD;
        bitSlot <= bitSlot + 1'b1;
        if (bitSlot == '0) begin
          // Line back high, only a glitch
          if (rxIn) begin
            busy <= 1'b0;
          end
        end else if (bitSlot == STOP_SLOT) begin
          // Framing error drops the byte
          busy    <= 1'b0;
          rxValid <= rxIn;
        end else begin
          // LSB arrives first
          shiftReg <= {rxIn, shiftReg[7:1]};
        end
      end
    end
  end

  assign rxByte = shiftReg;

endmodule

`default_nettype wire

//--- uartTx.sv
`timescale 1ns/1ps
`default_nettype none
`include "knightsTour_config.svh"

module uartTx (
  input  logic                 clk,
  input  logic                 reset,
  input  knightsTourPkg::byteT txByte,
  input  logic                 txStart,
  output logic                 tx,
  output logic                 txBusy
);

  localparam int CNT_W = $clog2(`KT_BAUD_DIV);
  localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(`KT_BAUD_DIV - 1);
  // Start, eight data bits, stop
  localparam logic [3:0] LAST_SLOT = 4'd9;

  logic [9:0]       frame;
  logic [CNT_W-1:0] baudCnt;
  logic [3:0]       bitSlot;

  always_ff @(posedge clk) begin
    if (reset) begin
      // All ones keeps the line idle
      frame   <= '1;
      txBusy  <= 1'b0;
      baudCnt <= '0;
      bitSlot <= '0;
    end else if (!txBusy) begin
      if (txStart) begin
        // Stop bit on top, start bit goes out first
        frame   <= {1'b1, txByte, 1'b0};
        txBusy  <= 1'b1;
        baudCnt <= FULL_LOAD;
        bitSlot <= '0;
      end
    end else if (baudCnt != '0) begin
      baudCnt <= baudCnt - 1'b1;
    end else begin
      // End of a bit slot, fill with idle level
      baudCnt <= FULL_LOAD;
      frame   <= {1'b1, frame[9:1]};
      bitSlot <= bitSlot + 1'b1;
      if (bitSlot == LAST_SLOT) begin
        txBusy <= 1'b0;
      end
    end
  end

  // Line driven straight from the shift register
  assign tx = frame[0];

endmodule

`default_nettype wire

//--- cmdLink.sv
`timescale 1ns/1ps
`default_nettype none

module cmdLink (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rx,
  output logic                 tx,
  output knightsTourPkg::cmdT  cmd,
  output logic                 cmdValid,
  input  knightsTourPkg::byteT respByte,
  input  logic                 respValid,
  output logic                 respReady
);

  import knightsTourPkg::*;

  byteT    rxByte;
  logic    rxValid;
  byteT    highByte;
  logic    lowPhase;
  cmdWordT cmdWord;
  logic    txStart;
  logic    txBusy;

  uartRx u_uartRx (
    .clk     (clk),
    .reset   (reset),
    .rx      (rx),
    .rxByte  (rxByte),
    .rxValid (rxValid)
  );

  // Byte phase, low means the next byte is the high byte
  always_ff @(posedge clk) begin
    if (reset) begin
      lowPhase <= 1'b0;
      cmdValid <= 1'b0;
    end else begin
      cmdValid <= rxValid && lowPhase;
      if (rxValid) begin
        lowPhase <= !lowPhase;
      end
    end
  end

  // High byte first, then the whole word
  assign cmdWord = {highByte, rxByte};

  always_ff @(posedge clk) begin
    if (rxValid && !lowPhase) begin
      highByte <= rxByte;
    end
    if (rxValid && lowPhase) begin
      cmd <= cmdT'(cmdWord);
    end
  end

  // Transmitter accepts whenever it is idle
  assign respReady = !txBusy;
  assign txStart   = respValid && respReady;

  uartTx u_uartTx (
    .clk     (clk),
    .reset   (reset),
    .txByte  (respByte),
    .txStart (txStart),
    .tx      (tx),
    .txBusy  (txBusy)
  );

endmodule

`default_nettype wire

//--- spiMaster.sv
`timescale 1ns/1ps
`default_nettype none
`include "knightsTour_config.svh"

module spiMaster (
  input  logic                    clk,
  input  logic                    reset,
  input  knightsTourPkg::spiWordT spiFrame,
  input  logic                    frameValid,
  output logic                    frameReady,
  output logic                    frameDone,
  output logic                    ssN,
  output logic                    sclk,
  output logic                    mosi,
  input  logic                    miso
);

  import knightsTourPkg::*;

  localparam int DIV_W = $clog2(`KT_SPI_DIV + 1);
  localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(`KT_SPI_DIV - 1);
  // 32 SCLK edges, then one more half period before deselect
  localparam logic [5:0] LAST_EDGE = 6'd32;

  logic             active;
  logic             tick;
  logic [DIV_W-1:0] divCnt;
  logic [5:0]       edgeCnt;
  spiWordT          shiftReg;
  logic             misoBit;

  assign frameReady = !active;
  // One event per SCLK half period
  assign tick = active && (divCnt == '0);
  // MSB first, held low while deselected
  assign mosi = !ssN && shiftReg[15];

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      ssN       <= 1'b1;
      sclk      <= 1'b0;
      frameDone <= 1'b0;
      divCnt    <= '0;
      edgeCnt   <= '0;
    end else begin
      frameDone <= 1'b0;
      if (!active) begin
        if (frameValid) begin
          active  <= 1'b1;
          ssN     <= 1'b0;
          divCnt  <= DIV_LOAD;
          edgeCnt <= '0;
        end
      end else if (!tick) begin
        divCnt <= divCnt - 1'b1;
      end else begin
        divCnt  <= DIV_LOAD;
        edgeCnt <= edgeCnt + 1'b1;
        if (edgeCnt == LAST_EDGE) begin
          active    <= 1'b0;
          ssN       <= 1'b1;
          frameDone <= 1'b1;
        end else begin
          // Even edges rise, odd edges fall
          sclk <= !edgeCnt[0];
        end
      end
    end
  end

  // Sample miso on rise, shift on fall so mosi moves on the falling edge
  always_ff @(posedge clk) begin
    if (frameValid && frameReady) begin
      shiftReg <= spiFrame;
    end else if (tick && edgeCnt != LAST_EDGE) begin
      if (!edgeCnt[0]) begin
        misoBit <= miso;
      end else begin
        shiftReg <= {shiftReg[14:0], misoBit};
      end
    end
  end

endmodule

`default_nettype wire

//--- cmdProc.sv
`timescale 1ns/1ps
`default_nettype none
`include "knightsTour_config.svh"

module cmdProc (
  input  logic                    clk,
  input  logic                    reset,
  input  knightsTourPkg::cmdT     cmd,
  input  logic                    cmdValid,
  output knightsTourPkg::spiWordT spiFrame,
  output logic                    frameValid,
  input  logic                    frameReady,
  input  logic                    frameDone,
  output knightsTourPkg::byteT    respByte,
  output logic                    respValid,
  input  logic                    respReady,
  output logic                    calDone,
  output knightsTourPkg::headingT heading
);

  import knightsTourPkg::*;

  localparam int IDX_W = $clog2(`KT_CAL_LEN);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`KT_CAL_LEN - 1);
  // Sensor register writes for calibration, sent in index order
  localparam spiWordT CAL_TABLE [`KT_CAL_LEN] = '{
    `KT_CAL_WORD0,
    `KT_CAL_WORD1,
    `KT_CAL_WORD2,
    `KT_CAL_WORD3
  };

  procStateT        state;
  procStateT        nextState;
  logic [IDX_W-1:0] calIdx;
  logic             lastFrame;
  logic             knownOp;

  assign lastFrame = (calIdx == LAST_IDX);
  assign knownOp   = (cmd.opcode == OP_CAL) || (cmd.opcode == OP_MOVE);

  // Handshake outputs follow the state
  assign spiFrame   = CAL_TABLE[calIdx];
  assign frameValid = (state == CAL_SEND);
  assign respValid  = (state == RESPOND);

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////
  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        // Commands are only taken here
        if (cmdValid) begin
          nextState = (cmd.opcode == OP_CAL) ? CAL_SEND : RESPOND;
        end
      end
      CAL_SEND: begin
        if (frameReady) begin
          nextState = CAL_WAIT;
        end
      end
      CAL_WAIT: begin
        // Next frame or done with the table
        if (frameDone) begin
          nextState = lastFrame ? RESPOND : CAL_SEND;
        end
      end
      RESPOND: begin
        if (respReady) begin
          nextState = IDLE;
        end
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // State and control registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      calIdx  <= '0;
      calDone <= 1'b0;
      heading <= '0;
    end else begin
      state <= nextState;
      if (state == IDLE && cmdValid) begin
        calIdx <= '0;
        if (cmd.opcode == OP_MOVE) begin
          heading <= cmd.operand;
        end
      end
      if (state == CAL_WAIT && frameDone) begin
        // Sticky until reset
        if (lastFrame) begin
          calDone <= 1'b1;
        end else begin
          calIdx <= calIdx + 1'b1;
        end
      end
    end
  end

  // Response chosen at decode, held through calibration
  always_ff @(posedge clk) begin
    if (state == IDLE && cmdValid) begin
      respByte <= knownOp ? `KT_ACK : `KT_NAK;
    end
  end

endmodule

`default_nettype wire

//--- knightsTour.sv
`timescale 1ns/1ps
`default_nettype none

module knightsTour (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rx,
  output logic                    tx,
  output logic                    ssN,
  output logic                    sclk,
  output logic                    mosi,
  input  logic                    miso,
  output logic                    calDone,
  output knightsTourPkg::headingT heading
);

  import knightsTourPkg::*;

  // Command path
  cmdT     cmd;
  logic    cmdValid;
  // Response path
  byteT    respByte;
  logic    respValid;
  logic    respReady;
  // Sensor frame path
  spiWordT spiFrame;
  logic    frameValid;
  logic    frameReady;
  logic    frameDone;

  // UART receive and transmit
  cmdLink u_cmdLink (
    .clk       (clk),
    .reset     (reset),
    .rx        (rx),
    .tx        (tx),
    .cmd       (cmd),
    .cmdValid  (cmdValid),
    .respByte  (respByte),
    .respValid (respValid),
    .respReady (respReady)
  );

  cmdProc u_cmdProc (
    .clk        (clk),
    .reset      (reset),
    .cmd        (cmd),
    .cmdValid   (cmdValid),
    .spiFrame   (spiFrame),
    .frameValid (frameValid),
    .frameReady (frameReady),
    .frameDone  (frameDone),
    .respByte   (respByte),
    .respValid  (respValid),
    .respReady  (respReady),
    .calDone    (calDone),
    .heading    (heading)
  );

  // Inertial sensor port
  spiMaster u_spiMaster (
    .clk        (clk),
    .reset      (reset),
    .spiFrame   (spiFrame),
    .frameValid (frameValid),
    .frameReady (frameReady),
    .frameDone  (frameDone),
    .ssN        (ssN),
    .sclk       (sclk),
    .mosi       (mosi),
    .miso       (miso)
  );

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk
);

  // 4 ns period, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- knightsTour_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module knightsTourAssertions (
  input logic clk,
  input logic reset,
  input logic tx,
  input logic ssN,
  input logic sclk,
  input logic mosi,
  input logic calDone
);

  // Clock idles low while deselected
  sclkIdle : assert property (@(posedge clk) disable iff (reset)
    ssN |-> !sclk)
    else $error("sclk high while ssN is high");

  // Data only moves on the falling edge
  mosiStable : assert property (@(posedge clk) disable iff (reset)
    ($past(sclk) && sclk) |-> $stable(mosi))
    else $error("mosi changed while sclk was high");

  // Serial line idles high out of reset
  txReset : assert property (@(posedge clk)
    reset |=> tx)
    else $error("tx not high during reset");

  // Sticky until reset
  calSticky : assert property (@(posedge clk) disable iff (reset)
    !$fell(calDone))
    else $error("calDone fell without reset");

endmodule

bind knightsTour knightsTourAssertions u_assertions (
  .clk     (clk),
  .reset   (reset),
  .tx      (tx),
  .ssN     (ssN),
  .sclk    (sclk),
  .mosi    (mosi),
  .calDone (calDone)
);

`default_nettype wire

//--- knightsTourTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "knightsTour_config.svh"

module knightsTourTb;

  import knightsTourPkg::*;

  localparam int NUM_STEPS      = 6;
  localparam int TIMEOUT_CYCLES = 6000;

  // One row of the stimulus table
  typedef struct {
    string   name;
    cmdWordT cmd;
    byteT    resp;
    headingT head;
    logic    cal;
    logic    spi;
  } stepT;

  logic    clk;
  logic    reset;
  logic    rx;
  logic    tx;
  logic    ssN;
  logic    sclk;
  logic    mosi;
  logic    miso;
  logic    calDone;
  headingT heading;

  stepT    steps [NUM_STEPS];
  spiWordT calWords [`KT_CAL_LEN];
  byteT    respQ [$];
  spiWordT spiQ [$];
  spiWordT spiShift;
  int      spiBits = 0;
  logic    calSticky;
  logic [7:0] lfsr;
  logic    prevSsn;
  logic    prevSclk;

  int mismatchCount = 0;
  int timeoutCount  = 0;
  int otherCount    = 0;

  tbClock u_clock (
    .clk (clk)
  );

  knightsTour u_dut (
    .clk     (clk),
    .reset   (reset),
    .rx      (rx),
    .tx      (tx),
    .ssN     (ssN),
    .sclk    (sclk),
    .mosi    (mosi),
    .miso    (miso),
    .calDone (calDone),
    .heading (heading)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // 8-bit Galois LFSR with taps 8 6 5 4
  function automatic logic [7:0] lfsrStep(input logic [7:0] state);
    return state[0] ? ((state >> 1) ^ 8'hB8) : (state >> 1);
  endfunction

  task automatic addStep(input int idx, input string name, input cmdWordT cmd,
                         input byteT resp, input headingT head, input logic cal,
                         input logic spi);
    steps[idx] = '{name, cmd, resp, head, cal, spi};
  endtask

  task automatic compareValue(input string testName, input string field,
                              input logic [15:0] expected, input logic [15:0] actual);
    assert (expected === actual) else begin
      mismatchCount++;
      $display("MISMATCH %s %s expected 0x%h actual 0x%h",
               testName, field, expected, actual);
    end
  endtask

  // Start bit, data LSB first and stop bit
  // Begins and ends on a falling clock edge
  task automatic sendByte(input byteT data);
    logic [9:0] bits;
    bits = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx = bits[i];
      repeat (`KT_BAUD_DIV) @(negedge clk);
    end
  endtask

  // Outputs must sit at their reset values
  task automatic checkIdle(input int cycles);
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (tx !== 1'b1 || ssN !== 1'b1 || sclk !== 1'b0 || calDone !== 1'b0 ||
          heading !== '0) begin
        bad = 1'b1;
      end
    end
    assert (!bad) else begin
      otherCount++;
      $display("Outputs left their reset values during the idle period after reset");
    end
  endtask

  task automatic runStep(input stepT st);
    int   cycles;
    logic calDropped;
    respQ.delete();
    spiQ.delete();
    calDropped = 1'b0;
    cycles     = 0;
    sendByte(st.cmd[15:8]);
    sendByte(st.cmd[7:0]);
    // Response byte marks the end of the command
    while (respQ.size() == 0 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (calSticky && calDone !== 1'b1) begin
        calDropped = 1'b1;
      end
    end
    if (respQ.size() == 0) begin
      timeoutCount++;
      $display("Timeout: no response byte for %s within %0d cycles",
               st.name, TIMEOUT_CYCLES);
      return;
    end
    // calDone already set when the ack goes out
    compareValue(st.name, "calDone", {15'd0, st.cal}, {15'd0, calDone});
    // Quiet gap long enough for a second byte to be decoded
    repeat (12 * `KT_BAUD_DIV) @(negedge clk);
    compareValue(st.name, "response count", 16'd1, 16'(respQ.size()));
    compareValue(st.name, "response", {8'd0, st.resp}, {8'd0, respQ[0]});
    compareValue(st.name, "heading", {4'd0, st.head}, {4'd0, heading});
    compareValue(st.name, "frame count", 16'(st.spi ? `KT_CAL_LEN : 0),
                 16'(spiQ.size()));
    if (st.spi && spiQ.size() == `KT_CAL_LEN) begin
      for (int i = 0; i < `KT_CAL_LEN; i++) begin
        compareValue(st.name, $sformatf("frame %0d", i), calWords[i], spiQ[i]);
      end
    end
    assert (!calDropped) else begin
      otherCount++;
      $display("calDone dropped while %s was running", st.name);
    end
    calSticky = st.cal;
  endtask

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  // UART response decoder sampling at bit centres
  initial begin : uartMonitor
    byteT data;
    forever begin
      @(negedge clk);
      if (!reset && tx === 1'b0) begin
        repeat (`KT_BAUD_DIV / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (`KT_BAUD_DIV) @(negedge clk);
          data[i] = tx;
        end
        repeat (`KT_BAUD_DIV) @(negedge clk);
        assert (tx === 1'b1) else begin
          otherCount++;
          $display("Response byte arrived with a low stop bit");
        end
        respQ.push_back(data);
      end
    end
  end

  // Mode 0 capture with MSB first
  always @(posedge sclk) begin
    if (ssN === 1'b0) begin
      spiShift = {spiShift[14:0], mosi};
      spiBits++;
      if (spiBits == 16) begin
        spiQ.push_back(spiShift);
        spiBits = 0;
      end
    end
  end

  always @(posedge ssN) begin
    if (spiBits != 0) begin
      otherCount++;
      $display("SPI frame ended after %0d bits", spiBits);
      spiBits = 0;
    end
  end

  // Sensor read data with one LFSR step per sampled bit
  // No step after the last falling edge of a frame
  always @(negedge clk) begin
    if (!reset && ssN === 1'b0 &&
        (prevSsn === 1'b1 ||
         (prevSclk === 1'b1 && sclk === 1'b0 && spiBits != 0))) begin
      lfsr = lfsrStep(lfsr);
      miso = lfsr[0];
    end
    prevSsn  = ssN;
    prevSclk = sclk;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : mainSequence
    reset     = 1'b1;
    rx        = 1'b1;
    miso      = 1'b0;
    lfsr      = 8'd29;
    calSticky = 1'b0;
    calWords  = '{`KT_CAL_WORD0, `KT_CAL_WORD1, `KT_CAL_WORD2, `KT_CAL_WORD3};
    // Name, command, response, heading after, calDone after, frames
    addStep(0, "nakBeforeCal", 16'h7001, `KT_NAK, 12'h000, 1'b0, 1'b0);
    addStep(1, "calFirst",     16'h2000, `KT_ACK, 12'h000, 1'b1, 1'b1);
    addStep(2, "moveAbc",      16'h4ABC, `KT_ACK, 12'hABC, 1'b1, 1'b0);
    addStep(3, "move123",      16'h4123, `KT_ACK, 12'h123, 1'b1, 1'b0);
    addStep(4, "nakUnknown",   16'h7001, `KT_NAK, 12'h123, 1'b1, 1'b0);
    addStep(5, "calSecond",    16'h2000, `KT_ACK, 12'h123, 1'b1, 1'b1);
    repeat (2) @(negedge clk);
    reset = 1'b0;
    checkIdle(50);
    for (int s = 0; s < NUM_STEPS; s++) begin
      runStep(steps[s]);
      if (timeoutCount != 0) begin
        break;
      end
    end
    $display("Errors: %0d mismatches, %0d timeouts, %0d other",
             mismatchCount, timeoutCount, otherCount);
    if (mismatchCount + timeoutCount + otherCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- knightsTour.f
+incdir+.
knightsTourPkg.sv
uartRx.sv
uartTx.sv
cmdLink.sv
spiMaster.sv
cmdProc.sv
knightsTour.sv
tbClock.sv
knightsTour_assertions.sv
knightsTourTb.sv

//--- Bender.yml
package:
  name: knightsTour

sources:
  - include_dirs:
      - .
    files:
      - knightsTourPkg.sv
      - uartRx.sv
      - uartTx.sv
      - cmdLink.sv
      - spiMaster.sv
      - cmdProc.sv
      - knightsTour.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClock.sv
      - knightsTour_assertions.sv
      - knightsTourTb.sv
